// File: Makefile
SRCS := $(wildcard src/*.sv bench/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_mem_wb
	./obj_dir/Vtb_mem_wb | awk '{ print } /^STATUS: PASS$$/ { ok = 1 } END { exit !ok }'

obj_dir/Vtb_mem_wb: compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_wb -f compile.f

clean:
	rm -rf obj_dir

// File: bench/tb_mem_wb.sv
`timescale 1ns/1ps

module tb_mem_wb;
    import rv32i_types_pkg::*;

    localparam logic [1:0] KIND_COMMIT = 2'd0;
    localparam logic [1:0] KIND_STORE  = 2'd1;
    localparam logic [1:0] KIND_ERROR  = 2'd2;
    localparam int         WAIT_LIMIT  = 40;

    // one table row of stimulus and what the model expects
    typedef struct packed {
        rv32i_control_word ctrl;
        reg_addr_t         rd;
        rv32i_word         addr;
        rv32i_word         pc;
        rv32i_word         uimm;
        logic              br_flag;
        rv32i_word         sdata;
        logic [1:0]        kind;
        logic              poke;
        rv32i_word         exp_val;
        rv32i_word         exp_reg;
    } op_entry_t;

    logic              clk;
    logic              rst_i;
    logic              issue_i;
    rv32i_control_word ctrl_i;
    reg_addr_t         rd_i;
    rv32i_word         alu_out_i;
    rv32i_word         pc_i;
    rv32i_word         u_imm_i;
    logic              br_en_i;
    rv32i_word         store_data_i;
    reg_addr_t         rs_addr_i;
    rv32i_word         rs_data_o;
    logic              wb_valid_o;
    reg_addr_t         wb_rd_o;
    rv32i_word         wb_data_o;
    logic              err_o;
    logic              busy_o;

    rv32i_word   model_mem [DMEM_WORDS];
    rv32i_word   model_regs [32];
    op_entry_t   ops [$];
    logic [31:0] lcg_state;
    int          n_pass;
    int          n_fail;

    mem_wb_unit DUT (
        .clk          (clk),
        .rst_i        (rst_i),
        .issue_i      (issue_i),
        .ctrl_i       (ctrl_i),
        .rd_i         (rd_i),
        .alu_out_i    (alu_out_i),
        .pc_i         (pc_i),
        .u_imm_i      (u_imm_i),
        .br_en_i      (br_en_i),
        .store_data_i (store_data_i),
        .rs_addr_i    (rs_addr_i),
        .rs_data_o    (rs_data_o),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o),
        .err_o        (err_o),
        .busy_o       (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic rv32i_word lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic rv32i_control_word make_ctrl(input regfilemux_sel_t sel, input logic ld,
                                                    input logic rd_m, input logic wr_m,
                                                    input store_size_t size);
        rv32i_control_word c;
        c.regfilemux_sel = sel;
        c.load_regfile   = ld;
        c.mem_read       = rd_m;
        c.mem_write      = wr_m;
        c.store_size     = size;
        return c;
    endfunction

    // runs the reference model on one op and appends it to the table
    task automatic push_op(input rv32i_control_word c, input reg_addr_t rd, input rv32i_word addr,
                           input rv32i_word sdata, input logic br, input logic poke);
        op_entry_t e;
        rv32i_word word;
        rv32i_word lane;
        rv32i_word mask;
        rv32i_word val;
        int        width;
        int        shamt;
        e.ctrl    = c;
        e.rd      = rd;
        e.addr    = addr;
        e.pc      = lcg_next() & 32'hfffffffc;
        e.uimm    = lcg_next() & 32'hfffff000;
        e.br_flag = br;
        e.sdata   = sdata;
        e.poke    = poke;
        if (c.mem_write) begin
            width = (c.store_size == sw) ? 4 : ((c.store_size == sh) ? 2 : 1);
        end else begin
            width = (c.regfilemux_sel == lw) ? 4 : ((c.regfilemux_sel inside {lh, lhu}) ? 2 : 1);
        end
        shamt = 8 * int'(addr[1:0]);
        word  = model_mem[addr[9:2]];
        lane  = word >> shamt;
        val   = '0;
        if ((c.mem_read || c.mem_write) && (addr % width) != 0) begin
            e.kind = KIND_ERROR;
        end else if (c.mem_write) begin
            e.kind = KIND_STORE;
            mask = (width == 4) ? 32'hffffffff : (((32'd1 << (8 * width)) - 32'd1) << shamt);
            model_mem[addr[9:2]] = (word & ~mask) | ((sdata << shamt) & mask);
        end else begin
            e.kind = KIND_COMMIT;
            case (c.regfilemux_sel)
                alu_out:  val = addr;
                br_en:    val = {31'b0, br};
                u_imm:    val = e.uimm;
                pc_plus4: val = e.pc + 32'd4;
                lw:       val = word;
                lh:       val = {{16{lane[15]}}, lane[15:0]};
                lhu:      val = {16'h0000, lane[15:0]};
                lb:       val = {{24{lane[7]}}, lane[7:0]};
                default:  val = {24'h000000, lane[7:0]};
            endcase
            if (rd != 5'd0) begin
                model_regs[rd] = val;
            end
        end
        e.exp_val = val;
        e.exp_reg = model_regs[rd];
        ops.push_back(e);
    endtask

    task automatic add_alu(input regfilemux_sel_t sel, input reg_addr_t rd, input logic br);
        push_op(make_ctrl(sel, 1'b1, 1'b0, 1'b0, sb), rd, lcg_next(), lcg_next(), br, 1'b0);
    endtask

    task automatic add_load(input regfilemux_sel_t sel, input reg_addr_t rd, input rv32i_word addr,
                            input logic poke);
        push_op(make_ctrl(sel, 1'b1, 1'b1, 1'b0, sb), rd, addr, lcg_next(), 1'b0, poke);
    endtask

    // stores name x1 as rd so x1 must never change
    task automatic add_store(input store_size_t size, input rv32i_word addr, input rv32i_word data);
        push_op(make_ctrl(alu_out, 1'b0, 1'b0, 1'b1, size), 5'd1, addr, data, 1'b0, 1'b0);
    endtask

    task automatic build_table();
        regfilemux_sel_t sels [4] = '{lb, lbu, lh, lhu};
        rv32i_word       base;
        rv32i_word       data;
        reg_addr_t       rd;
        add_alu(alu_out, 5'd1, 1'b0);
        add_alu(br_en, 5'd2, 1'b1);
        add_alu(br_en, 5'd3, 1'b0);
        add_alu(u_imm, 5'd4, 1'b0);
        add_alu(pc_plus4, 5'd5, 1'b0);
        for (int i = 0; i < 4; i++) begin
            base = lcg_next() & 32'h000000fc;
            add_store(sw, base, lcg_next());
            add_load(lw, 5'(6 + i), base, 1'b0);
        end
        // alternate which lanes carry a set sign bit
        rd = 5'd10;
        for (int i = 0; i < 4; i++) begin
            base = 32'h100 + 32'(4 * i);
            data = lcg_next();
            data = i[0] ? ((data | 32'h00800080) & 32'h7fff7fff)
                        : ((data & 32'h7f7f7f7f) | 32'h80008000);
            add_store(sw, base, data);
            for (int off = 0; off < 4; off++) begin
                for (int k = 0; k < 4; k++) begin
                    if (k < 2 || off % 2 == 0) begin
                        add_load(sels[k], rd, base + 32'(off), 1'b0);
                        rd = (rd == 5'd19) ? 5'd10 : rd + 5'd1;
                    end
                end
            end
        end
        // partial stores merged into a full word
        base = 32'h200;
        add_store(sw, base, lcg_next());
        add_store(sb, base + 32'd1, lcg_next());
        add_store(sh, base + 32'd2, lcg_next());
        add_load(lw, 5'd20, base, 1'b0);
        add_store(sb, base + 32'd3, lcg_next());
        add_store(sh, base, lcg_next());
        add_load(lw, 5'd21, base, 1'b0);
        // misaligned ops and then an aligned readback
        base = 32'h300;
        add_store(sw, base, lcg_next());
        add_alu(alu_out, 5'd22, 1'b0);
        add_load(lh, 5'd22, base + 32'd1, 1'b0);
        add_load(lhu, 5'd22, base + 32'd3, 1'b0);
        add_load(lw, 5'd22, base + 32'd2, 1'b0);
        add_store(sh, base + 32'd1, lcg_next());
        add_store(sw, base + 32'd2, lcg_next());
        add_store(sw, base + 32'd3, lcg_next());
        add_load(lw, 5'd23, base, 1'b0);
        add_alu(alu_out, 5'd0, 1'b0);
        add_load(lw, 5'd24, base, 1'b1);
    endtask

    task automatic run_op(input int idx, input op_entry_t e);
        int   cycles;
        logic bad;
        logic exp_err;
        bad          = 1'b0;
        exp_err      = (e.kind == KIND_ERROR);
        ctrl_i       = e.ctrl;
        rd_i         = e.rd;
        alu_out_i    = e.addr;
        pc_i         = e.pc;
        u_imm_i      = e.uimm;
        br_en_i      = e.br_flag;
        store_data_i = e.sdata;
        rs_addr_i    = e.rd;
        issue_i      = 1'b1;
        @(negedge clk);
        issue_i = 1'b0;
        // second op to x31 while the first is still in flight
        if (e.poke) begin
            if (busy_o !== 1'b1) begin
                $display("FAIL test %0d busy_o got %h exp %h", idx, busy_o, 1'b1);
                bad = 1'b1;
            end
            ctrl_i    = make_ctrl(alu_out, 1'b1, 1'b0, 1'b0, sb);
            rd_i      = 5'd31;
            alu_out_i = lcg_next() | 32'h1;
            issue_i   = 1'b1;
        end
        cycles = 0;
        while (wb_valid_o !== 1'b1 && err_o !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            issue_i = 1'b0;
            cycles++;
        end
        if (cycles >= WAIT_LIMIT) begin
            $display("test %0d: no wb_valid_o or err_o within %0d cycles", idx, WAIT_LIMIT);
            bad = 1'b1;
        end else begin
            if (err_o !== exp_err) begin
                $display("FAIL test %0d err_o got %h exp %h", idx, err_o, exp_err);
                bad = 1'b1;
            end
            if (wb_valid_o !== !exp_err) begin
                $display("FAIL test %0d wb_valid_o got %h exp %h", idx, wb_valid_o, !exp_err);
                bad = 1'b1;
            end
            if ((exp_err || !(e.ctrl.mem_read || e.ctrl.mem_write)) && cycles != 0) begin
                $display("test %0d: retired %0d cycles late, expected one cycle after issue",
                         idx, cycles);
                bad = 1'b1;
            end
            if (e.kind == KIND_COMMIT && wb_rd_o !== e.rd) begin
                $display("FAIL test %0d wb_rd_o got %h exp %h", idx, wb_rd_o, e.rd);
                bad = 1'b1;
            end
            if (e.kind == KIND_COMMIT && wb_data_o !== e.exp_val) begin
                $display("FAIL test %0d wb_data_o got %h exp %h", idx, wb_data_o, e.exp_val);
                bad = 1'b1;
            end
        end
        @(negedge clk);
        cycles = 0;
        while (busy_o !== 1'b0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= WAIT_LIMIT) begin
            $display("test %0d: busy_o stayed high for %0d cycles", idx, WAIT_LIMIT);
            bad = 1'b1;
        end
        if (rs_data_o !== e.exp_reg) begin
            $display("FAIL test %0d rs_data_o got %h exp %h", idx, rs_data_o, e.exp_reg);
            bad = 1'b1;
        end
        if (e.poke) begin
            rs_addr_i = 5'd31;
            @(negedge clk);
            if (rs_data_o !== 32'h0) begin
                $display("FAIL test %0d rs_data_o got %h exp %h", idx, rs_data_o, 32'h0);
                bad = 1'b1;
            end
        end
        if (bad) begin
            n_fail++;
            $display("test %0d failed", idx);
        end else begin
            n_pass++;
            $display("test %0d ok (rd x%0d)", idx, e.rd);
        end
    endtask

    initial begin
        rst_i        = 1'b1;
        issue_i      = 1'b0;
        ctrl_i       = '0;
        rd_i         = '0;
        alu_out_i    = '0;
        pc_i         = '0;
        u_imm_i      = '0;
        br_en_i      = 1'b0;
        store_data_i = '0;
        rs_addr_i    = '0;
        lcg_state    = 32'h96255988;
        n_pass       = 0;
        n_fail       = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        build_table();
        repeat (16) @(negedge clk);
        rst_i = 1'b0;
        @(negedge clk);
        if (busy_o !== 1'b0) begin
            $display("FAIL reset busy_o got %h exp %h", busy_o, 1'b0);
            n_fail++;
        end
        if (wb_valid_o !== 1'b0) begin
            $display("FAIL reset wb_valid_o got %h exp %h", wb_valid_o, 1'b0);
            n_fail++;
        end
        if (err_o !== 1'b0) begin
            $display("FAIL reset err_o got %h exp %h", err_o, 1'b0);
            n_fail++;
        end
        for (int i = 0; i < ops.size(); i++) begin
            run_op(i, ops[i]);
        end
        $display("tests %0d, passed %0d, failed %0d", ops.size(), n_pass, n_fail);
        if (n_fail == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
src/rv32i_types_pkg.sv
src/mem_wb_if.sv
src/wait_counter.sv
src/data_mem.sv
src/wb_stage.sv
src/regfile.sv
src/mem_seq_fsm.sv
src/mem_wb_unit.sv
bench/tb_mem_wb.sv

// File: src/data_mem.sv
`timescale 1ns/1ps

module data_mem (
    input  logic                       clk,
    input  logic                       we_i,
    input  logic [3:0]                 be_i,
    input  rv32i_types_pkg::rv32i_word addr_i,
    input  rv32i_types_pkg::rv32i_word wdata_i,
    mem_wb_if.mem                      bus
);
    import rv32i_types_pkg::*;

    rv32i_word                       mem [DMEM_WORDS];
    logic [$clog2(DMEM_WORDS)-1:0]   word_idx;

    // word organized, byte offset dropped
    assign word_idx = addr_i[$clog2(DMEM_WORDS)+1:2];

    // only the enabled lanes change
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (be_i[lane]) begin
                    mem[word_idx][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
                end
            end
        end
    end

    // whole word back, lane pick happens in writeback
    assign bus.mem_rdata = mem[word_idx];

    // a store always touches at least one lane
    assert property (@(posedge clk) we_i |-> (be_i != 4'b0000))
        else $error("data memory write with no byte enable at 0x%08h", addr_i);

endmodule

// File: src/mem_seq_fsm.sv
`timescale 1ns/1ps

module mem_seq_fsm (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               issue_i,
    input  rv32i_types_pkg::rv32i_control_word op_ctrl_i,
    input  rv32i_types_pkg::reg_addr_t         op_rd_i,
    input  rv32i_types_pkg::rv32i_word         op_alu_out_i,
    input  rv32i_types_pkg::rv32i_word         op_pc_i,
    input  rv32i_types_pkg::rv32i_word         op_u_imm_i,
    input  logic                               op_br_en_i,
    input  rv32i_types_pkg::rv32i_word         op_store_data_i,
    input  logic                               cnt_done_i,
    output logic                               cnt_load_o,
    output logic                               mem_we_o,
    output logic [3:0]                         mem_be_o,
    output rv32i_types_pkg::rv32i_word         mem_wdata_o,
    output logic                               wb_valid_o,
    output logic                               err_o,
    output logic                               busy_o,
    mem_wb_if.seq                              seq
);
    import rv32i_types_pkg::*;

    seq_state_t state_q;
    seq_state_t state_d;
    logic       accept;
    logic       is_mem;
    logic       is_half;
    logic       is_word;
    logic       misaligned;
    rv32i_word  store_data_q;

    assign accept = issue_i && (state_q == IDLE);
    assign is_mem = op_ctrl_i.mem_read || op_ctrl_i.mem_write;

    // access size: loads by mux select, stores by store size
    always_comb begin
        is_half = 1'b0;
        is_word = 1'b0;
        if (op_ctrl_i.mem_read) begin
            is_half = (op_ctrl_i.regfilemux_sel == lh) || (op_ctrl_i.regfilemux_sel == lhu);
            is_word = (op_ctrl_i.regfilemux_sel == lw);
        end else if (op_ctrl_i.mem_write) begin
            is_half = (op_ctrl_i.store_size == sh);
            is_word = (op_ctrl_i.store_size == sw);
        end
    end

    assign misaligned = (is_half && op_alu_out_i[0])
                     || (is_word && (op_alu_out_i[1:0] != 2'b00));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    if (!is_mem) begin
                        state_d = WRITEBACK;
                    end else if (misaligned) begin
                        state_d = ERROR;
                    end else begin
                        state_d = WAIT;
                    end
                end
            end
            WAIT: begin
                if (cnt_done_i) begin
                    state_d = ACCESS;
                end
            end
            ACCESS:    state_d = WRITEBACK;
            WRITEBACK: state_d = IDLE;
            ERROR:     state_d = IDLE;
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q  <= IDLE;
            seq.ctrl <= '0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                seq.ctrl <= op_ctrl_i;
            end
        end
    end

    // operation payload, held until the op retires
    always_ff @(posedge clk) begin
        if (accept) begin
            seq.rd       <= op_rd_i;
            seq.alu_out  <= op_alu_out_i;
            seq.pc       <= op_pc_i;
            seq.u_imm    <= op_u_imm_i;
            seq.br_en    <= op_br_en_i;
            store_data_q <= op_store_data_i;
        end
    end

    // byte strobes follow the low address bits
    always_comb begin
        case (seq.ctrl.store_size)
            sb:      mem_be_o = 4'b0001 << seq.alu_out[1:0];
            sh:      mem_be_o = 4'b0011 << seq.alu_out[1:0];
            default: mem_be_o = 4'b1111;
        endcase
    end

    // move store data up into its lane
    assign mem_wdata_o = store_data_q << {seq.alu_out[1:0], 3'b000};

    assign cnt_load_o = accept && is_mem && !misaligned;
    assign mem_we_o   = (state_q == ACCESS) && seq.ctrl.mem_write;
    assign wb_valid_o = (state_q == WRITEBACK);
    assign err_o      = (state_q == ERROR);
    assign busy_o     = (state_q != IDLE);

    // an op retires exactly once, either committed or flagged
    assert property (@(posedge clk) disable iff (rst_i) !(wb_valid_o && err_o))
        else $error("wb_valid_o and err_o together in state %s", state_q.name());
    assert property (@(posedge clk) disable iff (rst_i) wb_valid_o |=> !wb_valid_o)
        else $error("wb_valid_o held two cycles, now in state %s", state_q.name());
    assert property (@(posedge clk) disable iff (rst_i) err_o |=> !err_o)
        else $error("err_o held two cycles, now in state %s", state_q.name());

endmodule

// File: src/mem_wb_if.sv
`timescale 1ns/1ps

// one finished operation on its way to writeback
interface mem_wb_if;
    import rv32i_types_pkg::*;

    rv32i_control_word ctrl;
    reg_addr_t         rd;
    // alu result, also the data address
    rv32i_word         alu_out;
    rv32i_word         pc;
    rv32i_word         u_imm;
    logic              br_en;
    rv32i_word         mem_rdata;

    // sequencer holds the latched operation
    modport seq (
        output ctrl,
        output rd,
        output alu_out,
        output pc,
        output u_imm,
        output br_en
    );

    // data memory returns the addressed word
    modport mem (
        output mem_rdata
    );

    modport wb (
        input ctrl,
        input rd,
        input alu_out,
        input pc,
        input u_imm,
        input br_en,
        input mem_rdata
    );

endinterface

// File: src/mem_wb_unit.sv
`timescale 1ns/1ps

module mem_wb_unit (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               issue_i,
    input  rv32i_types_pkg::rv32i_control_word ctrl_i,
    input  rv32i_types_pkg::reg_addr_t         rd_i,
    input  rv32i_types_pkg::rv32i_word         alu_out_i,
    input  rv32i_types_pkg::rv32i_word         pc_i,
    input  rv32i_types_pkg::rv32i_word         u_imm_i,
    input  logic                               br_en_i,
    input  rv32i_types_pkg::rv32i_word         store_data_i,
    input  rv32i_types_pkg::reg_addr_t         rs_addr_i,
    output rv32i_types_pkg::rv32i_word         rs_data_o,
    output logic                               wb_valid_o,
    output rv32i_types_pkg::reg_addr_t         wb_rd_o,
    output rv32i_types_pkg::rv32i_word         wb_data_o,
    output logic                               err_o,
    output logic                               busy_o
);
    import rv32i_types_pkg::*;

    logic       cnt_load;
    logic       cnt_done;
    logic       mem_we;
    logic [3:0] mem_be;
    rv32i_word  mem_wdata;
    logic       load_regfile;

    mem_wb_if wb_bus ();

    mem_seq_fsm u_seq (
        .clk             (clk),
        .rst_i           (rst_i),
        .issue_i         (issue_i),
        .op_ctrl_i       (ctrl_i),
        .op_rd_i         (rd_i),
        .op_alu_out_i    (alu_out_i),
        .op_pc_i         (pc_i),
        .op_u_imm_i      (u_imm_i),
        .op_br_en_i      (br_en_i),
        .op_store_data_i (store_data_i),
        .cnt_done_i      (cnt_done),
        .cnt_load_o      (cnt_load),
        .mem_we_o        (mem_we),
        .mem_be_o        (mem_be),
        .mem_wdata_o     (mem_wdata),
        .wb_valid_o      (wb_valid_o),
        .err_o           (err_o),
        .busy_o          (busy_o),
        .seq             (wb_bus.seq)
    );

    wait_counter u_wait (
        .clk    (clk),
        .rst_i  (rst_i),
        .load_i (cnt_load),
        .done_o (cnt_done)
    );

    // address comes from the latched alu result
    data_mem u_dmem (
        .clk     (clk),
        .we_i    (mem_we),
        .be_i    (mem_be),
        .addr_i  (wb_bus.alu_out),
        .wdata_i (mem_wdata),
        .bus     (wb_bus.mem)
    );

    wb_stage u_wb (
        .bus            (wb_bus.wb),
        .wb_rd_o        (wb_rd_o),
        .wb_data_o      (wb_data_o),
        .load_regfile_o (load_regfile)
    );

    regfile u_rf (
        .clk            (clk),
        .rst_i          (rst_i),
        .we_i           (wb_valid_o),
        .load_regfile_i (load_regfile),
        .rd_i           (wb_rd_o),
        .wdata_i        (wb_data_o),
        .rs_addr_i      (rs_addr_i),
        .rs_data_o      (rs_data_o)
    );

    // latched select must name a real source when it commits
    assert property (@(posedge clk) disable iff (rst_i)
        wb_valid_o |-> (wb_bus.ctrl.regfilemux_sel inside
            {alu_out, br_en, u_imm, lw, pc_plus4, lh, lhu, lb, lbu}))
        else $error("unknown writeback select %0d", wb_bus.ctrl.regfilemux_sel);

endmodule

// File: src/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       we_i,
    input  logic                       load_regfile_i,
    input  rv32i_types_pkg::reg_addr_t rd_i,
    input  rv32i_types_pkg::rv32i_word wdata_i,
    input  rv32i_types_pkg::reg_addr_t rs_addr_i,
    output rv32i_types_pkg::rv32i_word rs_data_o
);
    import rv32i_types_pkg::*;

    rv32i_word regs [32];
    logic      wr_en;

    // commit pulse qualified by the op's own write flag
    assign wr_en = we_i && load_regfile_i && (rd_i != 5'd0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // x0 is hardwired
    assign rs_data_o = (rs_addr_i == 5'd0) ? '0 : regs[rs_addr_i];

endmodule

// File: src/rv32i_types_pkg.sv
package rv32i_types_pkg;

    // memory timing and geometry
    localparam int MEM_WAIT_CYCLES = 3;
    localparam int DMEM_WORDS      = 256;

    // the wait counter only ever holds MEM_WAIT_CYCLES-1 down to zero
    localparam int WAIT_CNT_W = (MEM_WAIT_CYCLES > 1) ? $clog2(MEM_WAIT_CYCLES) : 1;

    // basic datapath types
    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  reg_addr_t;

    // register file write source
    typedef enum logic [3:0] {
        alu_out  = 4'd0,
        br_en    = 4'd1,
        u_imm    = 4'd2,
        lw       = 4'd3,
        pc_plus4 = 4'd4,
        lh       = 4'd5,
        lhu      = 4'd6,
        lb       = 4'd7,
        lbu      = 4'd8
    } regfilemux_sel_t;

    // store width, same encoding as funct3
    typedef enum logic [1:0] {
        sb = 2'b00,
        sh = 2'b01,
        sw = 2'b10
    } store_size_t;

    // control bits that survive into the memory and writeback back end
    typedef struct packed {
        regfilemux_sel_t regfilemux_sel;
        logic            load_regfile;
        logic            mem_read;
        logic            mem_write;
        store_size_t     store_size;
    } rv32i_control_word;

    // sequencer states
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        WAIT      = 3'd1,
        ACCESS    = 3'd2,
        WRITEBACK = 3'd3,
        ERROR     = 3'd4
    } seq_state_t;

endpackage

// File: src/wait_counter.sv
`timescale 1ns/1ps

module wait_counter (
    input  logic clk,
    input  logic rst_i,
    input  logic load_i,
    output logic done_o
);
    import rv32i_types_pkg::*;

    logic [WAIT_CNT_W-1:0] cnt_q;

    // first wait cycle already starts on the load edge,
    // so done rises after exactly MEM_WAIT_CYCLES cycles
    always_ff @(posedge clk) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= WAIT_CNT_W'(MEM_WAIT_CYCLES - 1);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign done_o = (cnt_q == '0);

    // sequencer only starts a new wait from idle
    assert property (@(posedge clk) disable iff (rst_i) load_i |-> done_o)
        else $error("wait counter reloaded while running, count %0d", cnt_q);

endmodule

// File: src/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    mem_wb_if.wb                        bus,
    output rv32i_types_pkg::reg_addr_t  wb_rd_o,
    output rv32i_types_pkg::rv32i_word  wb_data_o,
    output logic                        load_regfile_o
);
    import rv32i_types_pkg::*;

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // lane pick by byte offset
    always_comb begin
        case (bus.alu_out[1:0])
            2'b00:   byte_lane = bus.mem_rdata[7:0];
            2'b01:   byte_lane = bus.mem_rdata[15:8];
            2'b10:   byte_lane = bus.mem_rdata[23:16];
            default: byte_lane = bus.mem_rdata[31:24];
        endcase
    end

    // halfwords are 2-aligned here, bit 1 picks the half
    assign half_lane = bus.alu_out[1] ? bus.mem_rdata[31:16] : bus.mem_rdata[15:0];

    always_comb begin
        unique case (bus.ctrl.regfilemux_sel)
            alu_out: begin
                wb_data_o = bus.alu_out;
            end
            br_en: begin
                wb_data_o = {31'b0, bus.br_en};
            end
            u_imm: begin
                wb_data_o = bus.u_imm;
            end
            lw: begin
                wb_data_o = bus.mem_rdata;
            end
            pc_plus4: begin
                wb_data_o = bus.pc + 32'd4;
            end
            lh: begin
                wb_data_o = {{16{half_lane[15]}}, half_lane};
            end
            lhu: begin
                wb_data_o = {16'h0000, half_lane};
            end
            lb: begin
                wb_data_o = {{24{byte_lane[7]}}, byte_lane};
            end
            lbu: begin
                wb_data_o = {24'h000000, byte_lane};
            end
            default: begin
                wb_data_o = bus.alu_out;
            end
        endcase
    end

    assign wb_rd_o        = bus.rd;
    assign load_regfile_o = bus.ctrl.load_regfile;

endmodule
